// ==== rtl/dummy_defines.svh ====
// Dummy instruction inserter constants
// Instruction encodings, default LFSR seeds and Galois feedback masks

`ifndef DUMMY_DEFINES_SVH
`define DUMMY_DEFINES_SVH

// Instruction and LFSR width
`define XLEN 32

// RISC-V major opcodes used by the dummies
`define OPCODE_OP     7'b0110011
`define OPCODE_BRANCH 7'b1100011

// funct3 codes, ADD and MUL share a value and differ in funct7
`define FUNCT3_ADD  3'b000
`define FUNCT3_AND  3'b111
`define FUNCT3_MUL  3'b000
`define FUNCT3_BLTU 3'b110

`define FUNCT7_ADD_AND 7'b0000000
`define FUNCT7_MUL     7'b0000001

`define REG_X0 5'b00000

// Default seeds, all nonzero so a lockup always recovers to a live state
`define LFSR0_SEED 32'hACE1_2B5D
`define LFSR1_SEED 32'h5A3C_96E1
`define LFSR2_SEED 32'h1F0E_7C43

// Right-shift Galois masks for maximal-length polynomials of degree 32
`define LFSR0_TAPS 32'h8020_0003
`define LFSR1_TAPS 32'hA300_0000
`define LFSR2_TAPS 32'hD000_0001

`endif

// ==== rtl/dummy_pkg.sv ====
// Dummy instruction inserter types
// Dummy kind encoding, instruction field layouts and the gap range helper

`default_nettype none

package dummy_pkg;

  `include "dummy_defines.svh"

  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'd0,
    DUMMY_AND  = 2'd1,
    DUMMY_MUL  = 2'd2,
    DUMMY_BLTU = 2'd3
  } dummy_kind_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_instr_t;

  // imm_hi holds imm[12|10:5] and imm_lo holds imm[4:1|11]
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } b_instr_t;

  // One instruction word seen as either an R-type or a B-type layout
  typedef union packed {
    r_instr_t r;
    b_instr_t b;
  } instr_u;

  // Mask of the lfsr1 bits that form the gap, set by the frequency range
  function automatic logic [5:0] gap_mask(input logic [3:0] freq);
    logic [5:0] mask;
    if (freq[3]) begin
      mask = 6'h3f;
    end else if (freq[2]) begin
      mask = 6'h1f;
    end else if (freq[1]) begin
      mask = 6'h0f;
    end else if (freq[0]) begin
      mask = 6'h07;
    end else begin
      mask = 6'h03;
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/rand_if.sv ====
// Random value bundle
// Carries the three LFSR values and the shared advance strobe

`timescale 1ns/1ps
`default_nettype none

`include "dummy_defines.svh"

interface rand_if;

  logic [`XLEN-1:0] lfsr0;
  logic [`XLEN-1:0] lfsr1;
  logic [`XLEN-1:0] lfsr2;

  // High in the cycle a dummy is issued, steps all three LFSRs
  logic             advance;

  // Issue stage needs the kind and the source registers
  modport issue (
    output advance,
    input  lfsr0,
    input  lfsr2
  );

  // Scheduler needs the gap value and sees when a dummy goes out
  modport sched (
    input advance,
    input lfsr1
  );

endinterface

`default_nettype wire

// ==== rtl/secure_lfsr.sv ====
// Seedable LFSR
// Galois LFSR that steps on advance, accepts a new seed, and falls back
// to its default seed whenever the next state would be zero

`timescale 1ns/1ps
`default_nettype none

`include "dummy_defines.svh"

module secure_lfsr #(
  parameter logic [`XLEN-1:0] SEED = `LFSR0_SEED,
  parameter logic [`XLEN-1:0] TAPS = `LFSR0_TAPS
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             advance,
  input  wire logic             seed_we,
  input  wire logic [`XLEN-1:0] seed_wdata,
  output logic      [`XLEN-1:0] value
);

  logic [`XLEN-1:0] state_q;
  logic [`XLEN-1:0] state_d;
  logic [`XLEN-1:0] step;

  // One Galois step, the bit shifted out decides the feedback
  always_comb begin
    step = state_q >> 1;
    if (state_q[0]) begin
      step = step ^ TAPS;
    end
  end

  // A seed write wins over stepping
  always_comb begin
    state_d = state_q;
    if (seed_we) begin
      state_d = seed_wdata;
    end else if (advance) begin
      state_d = step;
    end

    // Zero is the lockup state of an LFSR
    if (state_d == '0) begin
      state_d = SEED;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= SEED;
    end else begin
      state_q <= state_d;
    end
  end

  assign value = state_q;

  a_value_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    value != '0
  ) else $error("LFSR reached the all-zero lockup state");

endmodule

`default_nettype wire

// ==== rtl/dummy_scheduler.sv ====
// Dummy scheduler
// Counts accepted normal instructions and flags a dummy as due once the
// count reaches a random gap drawn from lfsr1

`timescale 1ns/1ps
`default_nettype none

module dummy_scheduler (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       dummy_en,
  input  wire logic [3:0] dummy_freq,
  input  wire logic       in_valid,
  input  wire logic       in_ready,
  rand_if.sched           rnd,
  output logic            dummy_due
);

  import dummy_pkg::*;

  localparam logic [6:0] COUNT_MAX = 7'd64;

  logic [6:0] count_q;
  logic [5:0] mask;
  logic [6:0] gap;
  logic       in_fire;

  // in_ready is low whenever a dummy is taken, so only normal
  // instructions are counted here
  assign in_fire = in_valid && in_ready;

  // Gap lies in 1..N where N is 4, 8, 16, 32 or 64
  assign mask = gap_mask(dummy_freq);
  assign gap  = {1'b0, rnd.lfsr1[5:0] & mask} + 7'd1;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (rnd.advance || !dummy_en) begin
      count_q <= '0;
    end else if (in_fire && (count_q != COUNT_MAX)) begin
      count_q <= count_q + 7'd1;
    end
  end

  assign dummy_due = dummy_en && (count_q >= gap);

  // Gap never exceeds 64, so a due dummy must clear the count first
  a_count_bounded: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= COUNT_MAX
  ) else $error("Normal instruction count went past 64");

endmodule

`default_nettype wire

// ==== rtl/dummy_issue.sv ====
// Dummy issue stage
// Output register of the fetch stream, loads either the incoming
// instruction or a freshly encoded dummy when one is due

`timescale 1ns/1ps
`default_nettype none

`include "dummy_defines.svh"

module dummy_issue (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             in_valid,
  input  wire logic [`XLEN-1:0] in_instr,
  output logic                  in_ready,
  input  wire logic             dummy_due,
  rand_if.issue                 rnd,
  output logic                  out_valid,
  output logic                  out_dummy,
  output logic      [`XLEN-1:0] out_instr,
  input  wire logic             out_ready
);

  import dummy_pkg::*;

  logic        active_q;
  logic        out_valid_q;
  logic        out_dummy_q;
  logic [`XLEN-1:0] out_instr_q;
  logic        load;
  dummy_kind_e kind;
  instr_u      dummy_word;

  // Stage can take a new word when empty or when the current one leaves
  // active_q keeps the handshake quiet until the cycle after reset
  assign load        = active_q && (!out_valid_q || out_ready);
  assign rnd.advance = load && dummy_due;
  assign in_ready    = load && !dummy_due;

  assign kind = dummy_kind_e'(rnd.lfsr0[1:0]);

  always_comb begin
    dummy_word = '0;
    case (kind)
      DUMMY_BLTU: begin
        // Branch offset zero so the dummy falls through either way
        dummy_word.b.imm_hi = '0;
        dummy_word.b.rs2    = rnd.lfsr2[9:5];
        dummy_word.b.rs1    = rnd.lfsr2[4:0];
        dummy_word.b.funct3 = `FUNCT3_BLTU;
        dummy_word.b.imm_lo = '0;
        dummy_word.b.opcode = `OPCODE_BRANCH;
      end
      default: begin
        dummy_word.r.funct7 = (kind == DUMMY_MUL) ? `FUNCT7_MUL : `FUNCT7_ADD_AND;
        dummy_word.r.rs2    = rnd.lfsr2[9:5];
        dummy_word.r.rs1    = rnd.lfsr2[4:0];
        // ADD and MUL share funct3 and differ only in funct7
        dummy_word.r.funct3 = (kind == DUMMY_AND) ? `FUNCT3_AND : `FUNCT3_ADD;
        dummy_word.r.rd     = `REG_X0;
        dummy_word.r.opcode = `OPCODE_OP;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (load) begin
        out_valid_q <= rnd.advance || (in_valid && in_ready);
      end
    end
  end

  // Payload follows the valid decision above
  always_ff @(posedge clk_i) begin
    if (rnd.advance) begin
      out_instr_q <= dummy_word;
      out_dummy_q <= 1'b1;
    end else if (in_valid && in_ready) begin
      out_instr_q <= in_instr;
      out_dummy_q <= 1'b0;
    end
  end

  assign out_valid = out_valid_q;
  assign out_dummy = out_dummy_q;
  assign out_instr = out_instr_q;

  a_hold_under_backpressure: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid && !out_ready |=>
      out_valid && $stable(out_instr) && $stable(out_dummy)
  ) else $error("Output changed while blocked by out_ready");

endmodule

`default_nettype wire

// ==== rtl/dummy_insert_top.sv ====
// Dummy instruction inserter top level
// Decodes seed writes and connects the three LFSRs, the scheduler and the
// issue stage around the fetch stream

`timescale 1ns/1ps
`default_nettype none

`include "dummy_defines.svh"

module dummy_insert_top (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             in_valid,
  input  wire logic [`XLEN-1:0] in_instr,
  output logic                  in_ready,
  output logic                  out_valid,
  output logic      [`XLEN-1:0] out_instr,
  output logic                  out_dummy,
  input  wire logic             out_ready,
  input  wire logic             dummy_en,
  input  wire logic [3:0]       dummy_freq,
  input  wire logic             seed_we,
  input  wire logic [1:0]       seed_sel,
  input  wire logic [`XLEN-1:0] seed_wdata
);

  rand_if rnd ();

  logic [2:0] lfsr_we;
  logic       dummy_due;

  // Select value 3 addresses no LFSR and is dropped
  always_comb begin
    lfsr_we = '0;
    case (seed_sel)
      2'd0:    lfsr_we[0] = seed_we;
      2'd1:    lfsr_we[1] = seed_we;
      2'd2:    lfsr_we[2] = seed_we;
      default: lfsr_we    = '0;
    endcase
  end

  secure_lfsr #(.SEED(`LFSR0_SEED), .TAPS(`LFSR0_TAPS)) u_lfsr0 (
    .clk_i, .rst_ni, .advance(rnd.advance), .seed_we(lfsr_we[0]),
    .seed_wdata, .value(rnd.lfsr0)
  );

  secure_lfsr #(.SEED(`LFSR1_SEED), .TAPS(`LFSR1_TAPS)) u_lfsr1 (
    .clk_i, .rst_ni, .advance(rnd.advance), .seed_we(lfsr_we[1]),
    .seed_wdata, .value(rnd.lfsr1)
  );

  secure_lfsr #(.SEED(`LFSR2_SEED), .TAPS(`LFSR2_TAPS)) u_lfsr2 (
    .clk_i, .rst_ni, .advance(rnd.advance), .seed_we(lfsr_we[2]),
    .seed_wdata, .value(rnd.lfsr2)
  );

  dummy_scheduler u_sched (
    .clk_i, .rst_ni, .dummy_en, .dummy_freq, .in_valid, .in_ready,
    .rnd(rnd.sched), .dummy_due
  );

  dummy_issue u_issue (
    .clk_i, .rst_ni, .in_valid, .in_instr, .in_ready, .dummy_due,
    .rnd(rnd.issue), .out_valid, .out_dummy, .out_instr, .out_ready
  );

endmodule

`default_nettype wire

// ==== testbench/dummy_insert_model.svh ====
// Reference model of the dummy instruction inserter
// Steps LFSR copies, applies the gap rule and encodes the expected dummies

`ifndef DUMMY_INSERT_MODEL_SVH
`define DUMMY_INSERT_MODEL_SVH

// Model LFSR states and the normal outputs seen since the last dummy
logic [`XLEN-1:0] m_lfsr0;
logic [`XLEN-1:0] m_lfsr1;
logic [`XLEN-1:0] m_lfsr2;
int unsigned      m_count;

function automatic logic [`XLEN-1:0] model_step(input logic [`XLEN-1:0] state,
                                                input logic [`XLEN-1:0] taps,
                                                input logic [`XLEN-1:0] seed);
  logic [`XLEN-1:0] nxt;
  nxt = {1'b0, state[`XLEN-1:1]};
  if (state[0]) begin
    nxt = nxt ^ taps;
  end
  return (nxt == '0) ? seed : nxt;
endfunction

function automatic logic [`XLEN-1:0] model_seed(input logic [`XLEN-1:0] wdata,
                                                input logic [`XLEN-1:0] seed);
  return (wdata == '0) ? seed : wdata;
endfunction

// Largest gap N for a frequency setting
function automatic int unsigned gap_limit(input logic [3:0] freq);
  if (freq == 4'd0) return 4;
  if (freq == 4'd1) return 8;
  if (freq < 4'd4) return 16;
  if (freq < 4'd8) return 32;
  return 64;
endfunction

function automatic int unsigned model_gap(input logic [`XLEN-1:0] l1, input logic [3:0] freq);
  return (l1 % gap_limit(freq)) + 1;
endfunction

function automatic logic [`XLEN-1:0] model_dummy(input logic [`XLEN-1:0] l0,
                                                 input logic [`XLEN-1:0] l2);
  case (l0[1:0])
    2'd0: return {`FUNCT7_ADD_AND, l2[9:5], l2[4:0], `FUNCT3_ADD, `REG_X0, `OPCODE_OP};
    2'd1: return {`FUNCT7_ADD_AND, l2[9:5], l2[4:0], `FUNCT3_AND, `REG_X0, `OPCODE_OP};
    2'd2: return {`FUNCT7_MUL, l2[9:5], l2[4:0], `FUNCT3_MUL, `REG_X0, `OPCODE_OP};
    default: return {7'd0, l2[9:5], l2[4:0], `FUNCT3_BLTU, 5'd0, `OPCODE_BRANCH};
  endcase
endfunction

task automatic model_reset();
  m_lfsr0 = `LFSR0_SEED;
  m_lfsr1 = `LFSR1_SEED;
  m_lfsr2 = `LFSR2_SEED;
  m_count = 0;
endtask

// Every issued dummy steps all three LFSRs and restarts the gap
task automatic model_advance();
  m_lfsr0 = model_step(m_lfsr0, `LFSR0_TAPS, `LFSR0_SEED);
  m_lfsr1 = model_step(m_lfsr1, `LFSR1_TAPS, `LFSR1_SEED);
  m_lfsr2 = model_step(m_lfsr2, `LFSR2_TAPS, `LFSR2_SEED);
  m_count = 0;
endtask

`endif

// ==== testbench/dummy_insert_tb.sv ====
// Testbench for the dummy instruction inserter
// Directed tests stream random instructions and compare every output
// transfer against the reference model

`timescale 1ns/1ps
`default_nettype none

`include "dummy_defines.svh"

module dummy_insert_tb;

  // About 500 normal instructions plus dummies and stalls take under 1500 cycles
  localparam int TIMEOUT_CYCLES = 4000;

  logic             clk_i;
  logic             rst_ni;
  logic             in_valid;
  logic [`XLEN-1:0] in_instr;
  logic             in_ready;
  logic             out_valid;
  logic [`XLEN-1:0] out_instr;
  logic             out_dummy;
  logic             out_ready;
  logic             dummy_en;
  logic [3:0]       dummy_freq;
  logic             seed_we;
  logic [1:0]       seed_sel;
  logic [`XLEN-1:0] seed_wdata;

  `include "dummy_insert_model.svh"

  integer           seed;
  logic [`XLEN-1:0] exp_q[$];
  logic [`XLEN-1:0] want;
  logic             bp_on;
  logic             prev_blocked;
  logic [`XLEN-1:0] prev_instr;
  logic             prev_dummy;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int dummies_seen = 0;
  int run_len = 0;
  int stall_cycles = 0;
  int cycles = 0;

  dummy_insert_top dut_i (
    .clk_i, .rst_ni, .in_valid, .in_instr, .in_ready, .out_valid, .out_instr,
    .out_dummy, .out_ready, .dummy_en, .dummy_freq, .seed_we, .seed_sel, .seed_wdata
  );

  always #10 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not complete within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // Output monitor that expects a dummy once the model gap is filled
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (prev_blocked) begin
        check_value("out_valid while blocked", out_valid, 1'b1);
        check_value("out_instr while blocked", out_instr, prev_instr);
        check_value("out_dummy while blocked", out_dummy, prev_dummy);
      end
      if (out_valid && out_ready) begin
        // Run length of normal outputs as the DUT marks them
        if (out_dummy) begin
          dummies_seen++;
          check_value("normals before dummy", run_len <= gap_limit(dummy_freq), 1'b1);
          run_len = 0;
        end else begin
          run_len++;
        end
        if (dummy_en && m_count >= model_gap(m_lfsr1, dummy_freq)) begin
          check_value("out_dummy", out_dummy, 1'b1);
          check_value("out_instr of dummy", out_instr, model_dummy(m_lfsr0, m_lfsr2));
          model_advance();
        end else if (exp_q.size() == 0) begin
          errors++;
          $display("Output 0x%08h at %0t arrived with no instruction pending", out_instr, $time);
        end else begin
          want = exp_q.pop_front();
          check_value("out_dummy", out_dummy, 1'b0);
          check_value("out_instr", out_instr, want);
          if (dummy_en) m_count++;
        end
      end
      if (out_valid && !out_ready) begin
        stall_cycles++;
        check_value("in_ready while blocked", in_ready, 1'b0);
      end
      prev_blocked = out_valid && !out_ready;
      prev_instr   = out_instr;
      prev_dummy   = out_dummy;
    end else begin
      prev_blocked = 1'b0;
    end
  end

  task automatic update_ready();
    out_ready = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
  endtask

  task automatic send_instr(input logic [`XLEN-1:0] word);
    logic taken;
    taken    = 1'b0;
    in_valid = 1'b1;
    in_instr = word;
    exp_q.push_back(word);
    while (!taken) begin
      @(posedge clk_i);
      taken = in_ready;
      #1;
      update_ready();
    end
    in_valid = 1'b0;
  endtask

  task automatic send_random(input int count);
    for (int i = 0; i < count; i++) begin
      send_instr($random(seed));
    end
  endtask

  // Waits until every instruction and any pending dummy has left
  task automatic drain();
    while (exp_q.size() != 0 || out_valid ||
           (dummy_en && m_count >= model_gap(m_lfsr1, dummy_freq))) begin
      @(posedge clk_i);
      #1;
      update_ready();
    end
  endtask

  // One cycle with the feature off clears the DUT count
  task automatic set_config(input logic en, input logic [3:0] freq);
    dummy_en = 1'b0;
    @(posedge clk_i);
    #1;
    dummy_freq = freq;
    dummy_en   = en;
    m_count    = 0;
    run_len    = 0;
  endtask

  task automatic write_seed(input logic [1:0] sel, input logic [`XLEN-1:0] data);
    seed_we    = 1'b1;
    seed_sel   = sel;
    seed_wdata = data;
    @(posedge clk_i);
    #1;
    seed_we = 1'b0;
    case (sel)
      2'd0: m_lfsr0 = model_seed(data, `LFSR0_SEED);
      2'd1: m_lfsr1 = model_seed(data, `LFSR1_SEED);
      2'd2: m_lfsr2 = model_seed(data, `LFSR2_SEED);
      default: ;
    endcase
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, errors - err_start);
    end
  endtask

  task automatic test_plain_stream();
    int e0;
    int d0;
    e0 = errors;
    d0 = dummies_seen;
    check_value("out_valid after reset", out_valid, 1'b0);
    check_value("in_ready after reset", in_ready, 1'b0);
    set_config(1'b0, 4'd0);
    send_random(40);
    drain();
    check_value("dummies with feature off", dummies_seen - d0, 0);
    finish_test("plain_stream", e0);
  endtask

  task automatic test_dummy_rate(input string name, input logic [3:0] freq, input int count);
    int e0;
    int d0;
    e0 = errors;
    d0 = dummies_seen;
    set_config(1'b1, freq);
    send_random(count);
    drain();
    check_value("dummies issued", dummies_seen > d0, 1'b1);
    finish_test(name, e0);
  endtask

  task automatic test_seed_writes();
    int e0;
    e0 = errors;
    set_config(1'b1, 4'd1);
    write_seed(2'd2, 32'h3C5A_0F96);
    send_random(40);
    drain();
    // A zero seed falls back to the default LFSR0 state
    write_seed(2'd0, 32'h0);
    send_random(40);
    drain();
    finish_test("seed_writes", e0);
  endtask

  task automatic test_backpressure();
    int e0;
    int s0;
    e0 = errors;
    s0 = stall_cycles;
    set_config(1'b1, 4'd2);
    bp_on = 1'b1;
    send_random(100);
    drain();
    bp_on     = 1'b0;
    out_ready = 1'b1;
    check_value("stall cycles seen", stall_cycles > s0, 1'b1);
    finish_test("backpressure", e0);
  endtask

  initial begin
    seed         = 32'h2dd2;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    in_valid     = 1'b0;
    in_instr     = '0;
    out_ready    = 1'b1;
    dummy_en     = 1'b0;
    dummy_freq   = 4'd0;
    seed_we      = 1'b0;
    seed_sel     = 2'd0;
    seed_wdata   = '0;
    bp_on        = 1'b0;
    prev_blocked = 1'b0;
    model_reset();
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    test_plain_stream();
    test_dummy_rate("dense_dummies", 4'd0, 120);
    test_dummy_rate("sparse_dummies", 4'd9, 200);
    test_seed_writes();
    test_backpressure();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches, %0d dummies",
             tests_run, tests_failed, checks, errors, dummies_seen);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+rtl
+incdir+testbench
rtl/dummy_pkg.sv
rtl/rand_if.sv
rtl/secure_lfsr.sv
rtl/dummy_scheduler.sv
rtl/dummy_issue.sv
rtl/dummy_insert_top.sv
testbench/dummy_insert_tb.sv
